/* common/fm_cfg.svh */
`ifndef FM_CFG_SVH
`define FM_CFG_SVH

// Slot map, 4 operators x 8 channels
`define FM_SLOTS 32
`define FM_CHANNELS 8

// Host address map
`define FM_ADDR_KEYON 8'h08
`define FM_ADDR_CH_BASE 8'h20 // RL/FB/CON, KC, KF, PMS/AMS at 8-byte steps
`define FM_ADDR_OP_BASE 8'h40 // Six operator groups at 32-byte steps

`endif

/* common/fm_reg_pkg.sv */
package fm_reg_pkg;

	// Data byte layouts, one per field group
	typedef struct packed { logic [1:0] rl; logic [2:0] fb; logic [2:0] con; } rl_fb_con_t;
	typedef struct packed { logic pad; logic [6:0] kc; } kc_t;
	typedef struct packed { logic [5:0] kf; logic [1:0] pad; } kf_t;
	typedef struct packed {
		logic       pad_hi;
		logic [2:0] pms;
		logic [1:0] pad_lo;
		logic [1:0] ams;
	} pms_ams_t;
	typedef struct packed { logic pad; logic [2:0] dt1; logic [3:0] mul; } dt1_mul_t;
	typedef struct packed { logic pad; logic [6:0] tl; } tl_t;
	typedef struct packed { logic [1:0] ks; logic pad; logic [4:0] ar; } ks_ar_t;
	typedef struct packed { logic amsen; logic [1:0] pad; logic [4:0] d1r; } amsen_d1r_t;
	typedef struct packed { logic [1:0] dt2; logic pad; logic [4:0] d2r; } dt2_d2r_t;
	typedef struct packed { logic [3:0] d1l; logic [3:0] rr; } d1l_rr_t;
	typedef struct packed { logic pad; logic [3:0] opmask; logic [2:0] ch; } keyon_t;

	// Same byte seen through the group selected by the address
	typedef union packed {
		rl_fb_con_t rl_fb_con;
		kc_t        kc;
		kf_t        kf;
		pms_ams_t   pms_ams;
		dt1_mul_t   dt1_mul;
		tl_t        tl;
		ks_ar_t     ks_ar;
		amsen_d1r_t amsen_d1r;
		dt2_d2r_t   dt2_d2r;
		d1l_rr_t    d1l_rr;
		keyon_t     keyon;
	} reg_data_u;

	typedef enum logic [3:0] {
		GRP_RL_FB_CON,
		GRP_KC,
		GRP_KF,
		GRP_PMS_AMS,
		GRP_DT1_MUL,
		GRP_TL,
		GRP_KS_AR,
		GRP_AMSEN_D1R,
		GRP_DT2_D2R,
		GRP_D1L_RR,
		GRP_KEYON
	} reg_group_e;

	typedef struct packed {
		logic       valid;
		reg_group_e group;
		logic [1:0] op;
		logic [2:0] ch;
		reg_data_u  data;
	} reg_update_t;

endpackage

/* common/fm_voice_pkg.sv */
package fm_voice_pkg;

	// Per operator, 42 bits
	typedef struct packed {
		logic [2:0] dt1;
		logic [3:0] mul;
		logic [6:0] tl;
		logic [1:0] ks;
		logic       amsen;
		logic [1:0] dt2;
		logic [3:0] d1l;
		logic [4:0] ar;
		logic [4:0] d1r;
		logic [4:0] d2r;
		logic [3:0] rr;
	} op_params_t;

	// Per channel, 26 bits
	typedef struct packed {
		logic [1:0] rl;
		logic [2:0] fb;
		logic [2:0] con;
		logic [6:0] kc;
		logic [5:0] kf;
		logic [1:0] ams;
		logic [2:0] pms;
	} ch_params_t;

	// Where the current operator takes its modulation input from
	typedef struct packed {
		logic use_prevprev1;
		logic use_internal_x;
		logic use_internal_y;
		logic use_prev2;
		logic use_prev1;
	} route_t;

	// Operator order M1, M2, C1, C2
	typedef struct packed {
		logic [1:0] op;
		logic [2:0] ch;
	} slot_t;

endpackage

/* regs/fm_keyon.sv */
`timescale 1ns/1ps
`include "fm_cfg.svh"

module fm_keyon (
	input  logic                    clk,
	input  logic                    rst,
	input  fm_reg_pkg::reg_update_t req,
	input  logic                    busy,
	input  fm_voice_pkg::slot_t     slot,
	input  logic                    frame_start,
	input  logic                    csm,
	input  logic                    overflow_a,
	output logic                    keyon
);
	import fm_reg_pkg::*;

	logic [`FM_SLOTS-1:0] kon_q;
	logic                 csm_arm;   // Overflow seen, waiting for next round
	logic                 csm_force; // Forcing slots 1..31 of the current round
	logic                 arm_now;
	logic                 force_cur;
	logic                 kon_wr;

	assign arm_now = csm && overflow_a;
	assign kon_wr  = busy && (req.group == GRP_KEYON) && (slot.ch == req.ch);

	// Stored state, one slot at a time as the round passes the channel
	always_ff @(posedge clk) begin
		if (rst)
			kon_q <= '0;
		else if (kon_wr)
			kon_q[slot] <= req.data.keyon.opmask[slot.op];
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			csm_arm   <= 1'b0;
			csm_force <= 1'b0;
		end else if (frame_start) begin
			csm_force <= csm_arm;
			csm_arm   <= arm_now; // Late pulse waits for the round after
		end else begin
			csm_arm   <= csm_arm || arm_now;
		end
	end

	// Slot 0 of the forced round still sees the armed flag
	assign force_cur = frame_start ? csm_arm : csm_force;
	assign keyon     = force_cur || kon_q[slot];

endmodule

/* design/fm_alg_route.sv */
`timescale 1ns/1ps

module fm_alg_route (
	input  logic [2:0]           con,
	input  logic [1:0]           cur_op,
	output fm_voice_pkg::route_t route
);

	logic [7:0] alg; // One-hot connection

	assign alg = 8'd1 << con;

	always_comb begin
		route = '0;
		case (cur_op)
			2'd0: begin // M1 always takes its own feedback
				route.use_prevprev1 = 1'b1;
				route.use_prev1     = 1'b1;
			end
			2'd1: begin // M2
				route.use_prevprev1 = alg[5];
				route.use_prev2     = |alg[2:0];
				route.use_prev1     = alg[1];
			end
			2'd2: begin // C1
				route.use_prev1 = |{alg[6:3], alg[0]};
			end
			default: begin // C2
				route.use_internal_x = alg[2];
				route.use_internal_y = |{alg[4:3], alg[1:0]};
				route.use_prev2      = alg[3];
				route.use_prev1      = alg[5] | alg[2];
			end
		endcase
	end

endmodule

/* regs/fm_reg_decode.sv */
`timescale 1ns/1ps
`include "fm_cfg.svh"

module fm_reg_decode (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     wr_addr,
	input  logic                     wr_data,
	input  logic [7:0]               din,
	input  logic                     busy,
	output fm_reg_pkg::reg_update_t  req
);
	import fm_reg_pkg::*;

	logic [7:0]  addr_q;
	logic        busy_d;
	logic [7:0]  ch_off;
	logic [7:0]  op_off;
	reg_data_u   din_u;
	reg_group_e  grp;
	logic        hit;
	reg_update_t next_req;

	assign din_u  = din;
	assign ch_off = addr_q - `FM_ADDR_CH_BASE;
	assign op_off = addr_q - `FM_ADDR_OP_BASE;

	always_comb begin
		grp = GRP_KEYON;
		hit = 1'b0;
		if (addr_q == `FM_ADDR_KEYON) begin
			hit = 1'b1;
		end else if (addr_q >= `FM_ADDR_OP_BASE) begin
			hit = 1'b1;
			case (op_off[7:5])
				3'd0:    grp = GRP_DT1_MUL;
				3'd1:    grp = GRP_TL;
				3'd2:    grp = GRP_KS_AR;
				3'd3:    grp = GRP_AMSEN_D1R;
				3'd4:    grp = GRP_DT2_D2R;
				default: grp = GRP_D1L_RR;
			endcase
		end else if (addr_q >= `FM_ADDR_CH_BASE) begin
			hit = 1'b1;
			case (ch_off[4:3])
				2'd0:    grp = GRP_RL_FB_CON;
				2'd1:    grp = GRP_KC;
				2'd2:    grp = GRP_KF;
				default: grp = GRP_PMS_AMS;
			endcase
		end

		next_req.valid = 1'b1;
		next_req.group = grp;
		next_req.op    = addr_q[4:3];
		next_req.ch    = (grp == GRP_KEYON) ? din_u.keyon.ch : addr_q[2:0];
		next_req.data  = din_u;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			addr_q <= '0;
			busy_d <= 1'b0;
			req    <= '0;
		end else begin
			busy_d <= busy;
			if (wr_addr)
				addr_q <= din;
			if (busy_d && !busy)
				req.valid <= 1'b0; // Round done
			else if (wr_data && !req.valid && !busy && hit)
				req <= next_req; // Strobes during a pending update are dropped
		end
	end

endmodule

/* regs/fm_reg_file.sv */
`timescale 1ns/1ps
`include "fm_cfg.svh"

module fm_reg_file (
	input  logic                     clk,
	input  logic                     rst,
	input  fm_reg_pkg::reg_update_t  req,
	input  logic                     csm,
	input  logic                     overflow_a,
	output logic                     busy,
	output fm_voice_pkg::slot_t      slot,
	output logic                     frame_start,
	output fm_voice_pkg::op_params_t op_params,
	output fm_voice_pkg::ch_params_t ch_params,
	output logic                     keyon,
	output fm_voice_pkg::route_t     route
);
	import fm_reg_pkg::*;
	import fm_voice_pkg::*;

	slot_t      slot_q;
	slot_t      next_slot;
	logic       last_slot;

	op_params_t op_mem [`FM_SLOTS];
	ch_params_t ch_mem [`FM_CHANNELS];
	op_params_t op_q;  // Contents of slot_q
	ch_params_t ch_q;
	op_params_t op_wr;
	ch_params_t ch_wr;
	logic       op_hit;
	logic       ch_hit;

	assign next_slot = slot_t'(slot_q + 5'd1);
	assign last_slot = slot_q == slot_t'(`FM_SLOTS - 1);

	always_ff @(posedge clk) begin
		if (rst) begin
			slot_q      <= '0;
			frame_start <= 1'b0;
			busy        <= 1'b0;
		end else begin
			slot_q      <= next_slot;
			frame_start <= next_slot == '0;
			if (last_slot)
				busy <= req.valid && !busy; // One full round per request
		end
	end

	assign op_hit = busy && (slot_q == {req.op, req.ch});
	assign ch_hit = busy && (slot_q.ch == req.ch);

	// Replace the requested group, keep the rest
	always_comb begin
		op_wr = op_q;
		ch_wr = ch_q;
		case (req.group)
			GRP_RL_FB_CON: begin
				ch_wr.rl  = req.data.rl_fb_con.rl;
				ch_wr.fb  = req.data.rl_fb_con.fb;
				ch_wr.con = req.data.rl_fb_con.con;
			end
			GRP_KC: ch_wr.kc = req.data.kc.kc;
			GRP_KF: ch_wr.kf = req.data.kf.kf;
			GRP_PMS_AMS: begin
				ch_wr.pms = req.data.pms_ams.pms;
				ch_wr.ams = req.data.pms_ams.ams;
			end
			GRP_DT1_MUL: begin
				op_wr.dt1 = req.data.dt1_mul.dt1;
				op_wr.mul = req.data.dt1_mul.mul;
			end
			GRP_TL: op_wr.tl = req.data.tl.tl;
			GRP_KS_AR: begin
				op_wr.ks = req.data.ks_ar.ks;
				op_wr.ar = req.data.ks_ar.ar;
			end
			GRP_AMSEN_D1R: begin
				op_wr.amsen = req.data.amsen_d1r.amsen;
				op_wr.d1r   = req.data.amsen_d1r.d1r;
			end
			GRP_DT2_D2R: begin
				op_wr.dt2 = req.data.dt2_d2r.dt2;
				op_wr.d2r = req.data.dt2_d2r.d2r;
			end
			GRP_D1L_RR: begin
				op_wr.d1l = req.data.d1l_rr.d1l;
				op_wr.rr  = req.data.d1l_rr.rr;
			end
			default: ; // Key-on lives in fm_keyon
		endcase
	end

	// Read one slot ahead so data lines up with slot_q
	always_ff @(posedge clk) begin
		op_q <= op_mem[next_slot];
		if (op_hit)
			op_mem[slot_q] <= op_wr;
	end

	// next_slot.ch never equals slot_q.ch, no read/write clash
	always_ff @(posedge clk) begin
		ch_q <= ch_mem[next_slot.ch];
		if (ch_hit)
			ch_mem[slot_q.ch] <= ch_wr;
	end

	assign slot      = slot_q;
	assign op_params = op_q;
	assign ch_params = ch_q;

	fm_keyon u_keyon (
		.clk         (clk),
		.rst         (rst),
		.req         (req),
		.busy        (busy),
		.slot        (slot_q),
		.frame_start (frame_start),
		.csm         (csm),
		.overflow_a  (overflow_a),
		.keyon       (keyon)
	);

	fm_alg_route u_alg_route (
		.con    (ch_q.con),
		.cur_op (slot_q.op),
		.route  (route)
	);

endmodule

/* design/fm_reg_top.sv */
`timescale 1ns/1ps

module fm_reg_top (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     wr_addr,
	input  logic                     wr_data,
	input  logic [7:0]               din,
	input  logic                     csm,
	input  logic                     overflow_a,
	output logic                     busy,
	output fm_voice_pkg::slot_t      slot,
	output logic                     frame_start,
	output fm_voice_pkg::op_params_t op_params,
	output fm_voice_pkg::ch_params_t ch_params,
	output logic                     keyon,
	output fm_voice_pkg::route_t     route
);
	import fm_reg_pkg::*;

	reg_update_t req; // Pending host update

	fm_reg_decode u_decode (
		.clk     (clk),
		.rst     (rst),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.din     (din),
		.busy    (busy),
		.req     (req)
	);

	fm_reg_file u_reg_file (
		.clk         (clk),
		.rst         (rst),
		.req         (req),
		.csm         (csm),
		.overflow_a  (overflow_a),
		.busy        (busy),
		.slot        (slot),
		.frame_start (frame_start),
		.op_params   (op_params),
		.ch_params   (ch_params),
		.keyon       (keyon),
		.route       (route)
	);

endmodule

/* test/fm_reg_tb.sv */
`timescale 1ns/1ps
`include "fm_cfg.svh"

module fm_reg_tb;
	import fm_reg_pkg::*;
	import fm_voice_pkg::*;

	typedef struct packed {
		op_params_t op;
		ch_params_t ch;
		logic       kon;
		route_t     route;
	} expect_t;

	// Init writes all registers, then the directed and random tests
	localparam int N_WRITES        = 192 + 32 + 40 + 24 + 3 + 16;
	localparam int WATCHDOG_CYCLES = N_WRITES * 80 + 2000;

	logic       clk = 1'b0;
	logic       rst;
	logic       wr_addr;
	logic       wr_data;
	logic [7:0] din;
	logic       csm;
	logic       overflow_a;
	logic       busy;
	slot_t      slot;
	logic       frame_start;
	op_params_t op_params;
	ch_params_t ch_params;
	logic       keyon;
	route_t     route;

	op_params_t           op_sh [`FM_SLOTS]; // Shadow of what the host wrote
	ch_params_t           ch_sh [`FM_CHANNELS];
	logic [`FM_SLOTS-1:0] kon_sh;

	integer     seed = 32'h77c1fc46;
	int         errors = 0;
	int         checks = 0;
	int         rounds = 0;
	logic       check_on = 1'b0;
	int         run_cyc;
	logic       armed;       // Model of a pending CSM overflow
	logic       force_round;
	logic       round_ok;
	logic       busy_round;  // Busy level seen at the last frame_start
	expect_t    exp_now;
	logic [31:0] r;

	fm_reg_top uut (
		.clk         (clk),
		.rst         (rst),
		.wr_addr     (wr_addr),
		.wr_data     (wr_data),
		.din         (din),
		.csm         (csm),
		.overflow_a  (overflow_a),
		.busy        (busy),
		.slot        (slot),
		.frame_start (frame_start),
		.op_params   (op_params),
		.ch_params   (ch_params),
		.keyon       (keyon),
		.route       (route)
	);

	always #10 clk = ~clk;

	task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] want);
		checks++;
		if (got !== want) begin
			errors++;
			$display("[ERROR] t=%0t %s: got %0h, expected %0h", $time, name, got, want);
		end
	endtask

	// OPM connection table with rows of {C2, C1, M2, M1}
	function automatic route_t route_ref(input logic [2:0] con, input logic [1:0] op);
		logic [19:0] row;
		case (con)
			3'd0:    row = {5'b00100, 5'b00001, 5'b00010, 5'b10001};
			3'd1:    row = {5'b00100, 5'b00000, 5'b00011, 5'b10001};
			3'd2:    row = {5'b01001, 5'b00000, 5'b00010, 5'b10001};
			3'd3:    row = {5'b00110, 5'b00001, 5'b00000, 5'b10001};
			3'd4:    row = {5'b00100, 5'b00001, 5'b00000, 5'b10001};
			3'd5:    row = {5'b00001, 5'b00001, 5'b10000, 5'b10001};
			3'd6:    row = {5'b00000, 5'b00001, 5'b00000, 5'b10001};
			default: row = {5'b00000, 5'b00000, 5'b00000, 5'b10001};
		endcase
		return route_t'(row[op*5 +: 5]);
	endfunction

	function automatic expect_t expected(input slot_t s, input logic force_on);
		expect_t e;
		e.op    = op_sh[s];
		e.ch    = ch_sh[s.ch];
		e.kon   = force_on | kon_sh[s];
		e.route = route_ref(ch_sh[s.ch].con, s.op);
		return e;
	endfunction

	// Merge a host write into the shadow by address map and byte layout
	function automatic void apply_write(input logic [7:0] addr, input logic [7:0] d);
		logic [4:0] s;
		logic [2:0] c;
		logic [7:0] off;
		int         n;
		s = addr[4:0];
		c = addr[2:0];
		if (addr == `FM_ADDR_KEYON) begin
			for (n = 0; n < 4; n++)
				kon_sh[{n[1:0], d[2:0]}] = d[3 + n];
		end else if (addr >= `FM_ADDR_OP_BASE) begin
			off = addr - `FM_ADDR_OP_BASE;
			case (off[7:5])
				3'd0: op_sh[s] = {d[6:4], d[3:0], op_sh[s].tl, op_sh[s][27:0]};
				3'd1: op_sh[s].tl = d[6:0];
				3'd2: begin
					op_sh[s].ks = d[7:6];
					op_sh[s].ar = d[4:0];
				end
				3'd3: begin
					op_sh[s].amsen = d[7];
					op_sh[s].d1r   = d[4:0];
				end
				3'd4: begin
					op_sh[s].dt2 = d[7:6];
					op_sh[s].d2r = d[4:0];
				end
				default: begin
					op_sh[s].d1l = d[7:4];
					op_sh[s].rr  = d[3:0];
				end
			endcase
		end else if (addr >= `FM_ADDR_CH_BASE) begin
			off = addr - `FM_ADDR_CH_BASE;
			case (off[4:3])
				2'd0: begin
					ch_sh[c].rl  = d[7:6];
					ch_sh[c].fb  = d[5:3];
					ch_sh[c].con = d[2:0];
				end
				2'd1: ch_sh[c].kc = d[6:0];
				2'd2: ch_sh[c].kf = d[7:2];
				default: begin
					ch_sh[c].pms = d[6:4];
					ch_sh[c].ams = d[1:0];
				end
			endcase
		end
	endfunction

	task automatic strobe_pair(input logic [7:0] addr, input logic [7:0] data);
		@(posedge clk);
		wr_addr <= 1'b1;
		din     <= addr;
		@(posedge clk);
		wr_addr <= 1'b0;
		wr_data <= 1'b1;
		din     <= data;
		@(posedge clk);
		wr_data <= 1'b0;
	endtask

	task automatic wait_busy(input logic level, output logic ok);
		int n;
		n = 0;
		while (busy !== level && n < 70) begin
			@(posedge clk);
			n++;
		end
		ok = (busy === level);
	endtask

	// The shadow takes the write at busy rise within a skipped round
	task automatic write_reg(input logic [7:0] addr, input logic [7:0] data);
		logic ok;
		strobe_pair(addr, data);
		wait_busy(1'b1, ok);
		if (!ok) begin
			errors++;
			$display("Write of %h to address %h never raised busy", data, addr);
		end else begin
			apply_write(addr, data);
			wait_busy(1'b0, ok);
			if (!ok) begin
				errors++;
				$display("Busy never fell after the write of %h to address %h", data, addr);
			end
		end
	endtask

	// Second pair lands inside the busy round and must be dropped
	task automatic write_with_drop(input logic [7:0] addr, input logic [7:0] keep,
		input logic [7:0] drop);
		logic ok;
		strobe_pair(addr, keep);
		wait_busy(1'b1, ok);
		if (!ok) begin
			errors++;
			$display("Write of %h to address %h never raised busy", keep, addr);
		end else begin
			apply_write(addr, keep);
			strobe_pair(addr, drop);
			wait_busy(1'b0, ok);
			if (!ok) begin
				errors++;
				$display("Busy never fell after the write of %h to address %h", keep, addr);
			end
		end
	endtask

	task automatic pulse_overflow();
		@(posedge clk);
		while (slot != 5'd10)
			@(posedge clk);
		overflow_a <= 1'b1;
		@(posedge clk);
		overflow_a <= 1'b0;
	endtask

	// Per-cycle compare at the falling edge
	always @(negedge clk) begin
		if (rst) begin
			run_cyc     = 0;
			armed       = 1'b0;
			force_round = 1'b0;
			round_ok    = 1'b0;
			busy_round  = 1'b0;
		end else begin
			if (run_cyc < 32)
				check_val("keyon", 64'(keyon), 64'(0));
			check_val("slot", 64'(slot), 64'(run_cyc % 32));
			check_val("frame_start", 64'(frame_start), 64'(run_cyc != 0 && run_cyc % 32 == 0));
			run_cyc++;
			if (frame_start) begin
				// One busy round per request, never two in a row
				if (busy_round)
					check_val("busy", 64'(busy), 64'(0));
				busy_round  = busy;
				force_round = armed;
				armed       = csm && overflow_a;
				round_ok    = check_on && !busy; // Busy rounds hold a write in flight
				if (round_ok)
					rounds++;
			end else begin
				check_val("busy", 64'(busy), 64'(busy_round)); // Only changes at the wrap
				armed = armed || (csm && overflow_a);
			end
			if (round_ok) begin
				exp_now = expected(slot, force_round);
				check_val("op_params", 64'(op_params), 64'(exp_now.op));
				check_val("ch_params", 64'(ch_params), 64'(exp_now.ch));
				check_val("keyon", 64'(keyon), 64'(exp_now.kon));
				check_val("route", 64'(route), 64'(exp_now.route));
			end
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
		$display("Done: %0d checks, %0d rounds, %0d errors", checks, rounds, errors);
		$display("TESTBENCH FAILED");
		$finish;
	end

	initial begin
		rst        <= 1'b1;
		wr_addr    <= 1'b0;
		wr_data    <= 1'b0;
		din        <= 8'h00;
		csm        <= 1'b0;
		overflow_a <= 1'b0;
		kon_sh      = '0;
		repeat (8) @(posedge clk);
		rst <= 1'b0;
		repeat (70) @(posedge clk); // Slot walk and idle state

		// Fill every register since the memories come up unknown
		for (int i = 0; i < 192; i++) begin
			r = $random(seed);
			write_reg(`FM_ADDR_OP_BASE + 8'(i), r[7:0]);
		end
		for (int i = 0; i < 32; i++) begin
			r = $random(seed);
			write_reg(`FM_ADDR_CH_BASE + 8'(i), r[7:0]);
		end
		check_on = 1'b1;

		for (int i = 0; i < 40; i++) begin
			r = $random(seed);
			write_reg(`FM_ADDR_OP_BASE + {r[10:8] % 3'd6, r[4:0]}, r[23:16]);
		end

		// Connection sweep first, then any channel group
		for (int i = 0; i < 8; i++) begin
			r = $random(seed);
			write_reg(`FM_ADDR_CH_BASE + {5'b0, r[2:0]}, {r[15:11], 3'(i)});
		end
		for (int i = 0; i < 16; i++) begin
			r = $random(seed);
			write_reg(`FM_ADDR_CH_BASE + {3'b0, r[9:8], r[2:0]}, r[23:16]);
		end

		write_with_drop(8'h65, 8'h12, 8'h6c);
		write_reg(8'h65, 8'h33);

		for (int i = 0; i < 16; i++) begin
			r = $random(seed);
			write_reg(`FM_ADDR_KEYON, {1'b0, r[3:0], 3'(i)});
		end

		pulse_overflow(); // Ignored while csm is low
		repeat (70) @(posedge clk);
		csm <= 1'b1;
		pulse_overflow();
		repeat (100) @(posedge clk);
		csm <= 1'b0;
		repeat (70) @(posedge clk);

		if (rounds == 0) begin
			errors++;
			$display("No full round was ever compared against the shadow");
		end
		$display("Done: %0d checks, %0d rounds, %0d errors", checks, rounds, errors);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

/* all.f */
+incdir+common
common/fm_reg_pkg.sv
common/fm_voice_pkg.sv
regs/fm_keyon.sv
design/fm_alg_route.sv
regs/fm_reg_decode.sv
regs/fm_reg_file.sv
design/fm_reg_top.sv
test/fm_reg_tb.sv

/* Makefile */
TOP := fm_reg_tb
LOG := sim.log

SRCS := $(wildcard common/*.sv common/*.svh regs/*.sv design/*.sv test/*.sv)

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): all.f $(SRCS)
	verilator --binary --timing -Wno-fatal -f all.f --top-module $(TOP) -o V$(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

lint:
	verilator --lint-only -Wall -f all.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)
